/* Bender.yml */
package:
  name: color_game

sources:
  - files:
      - hw/color_game_pkg.sv
      - hw/tick_divider.sv
      - hw/screen_painter.sv
      - hw/player_tracker.sv
      - hw/player_panel.sv
      - hw/color_game_top.sv
  - target: test
    files:
      - sim/tb_color_game.sv

/* hw/color_game_pkg.sv */
package color_game_pkg;

    // screen size in pixels
    localparam int screen_width  = 160;
    localparam int screen_height = 120;

    typedef logic [7:0] x_coord_t;    // pixel column
    typedef logic [6:0] y_coord_t;    // pixel row
    typedef logic [2:0] colour_t;     // {red, green, blue}, same layout for buttons
    typedef logic [6:0] score_t;      // 0 to 99
    typedef logic [3:0] lives_t;      // 0 to 8
    typedef logic [1:0] speed_sel_t;  // larger is faster
    typedef logic [6:0] seg_t;        // active low, g down to a

    localparam lives_t  start_lives = 4'd8;
    localparam score_t  max_score   = 7'd99;
    localparam colour_t bar_colour  = 3'b100;  // red

    // checkpoint columns 15, 45, 75, 105, 135
    localparam int checkpoint_first = 15;
    localparam int checkpoint_step  = 30;

    // note rows 6, 12 ... 96
    localparam int row_first = 6;
    localparam int row_step  = 6;
    localparam int row_last  = 96;

    localparam int note_count = 48;

    // entry 0 sits in the top three bits
    localparam logic [3*note_count-1:0] note_pattern = {
        48'b100_010_001_010_100_100_001_100_100_001_010_001_100_010_100_001,
        48'b100_001_010_100_001_100_010_010_100_010_001_010_100_001_010_001,
        48'b100_100_100_001_001_100_001_010_100_010_001_100_010_100_001_010
    };

    typedef enum logic [2:0] {
        setup_bar,
        next_bar,
        wait_start,
        play_row,
        next_row,
        game_over
    } painter_state_t;

endpackage

/* hw/color_game_top.sv */
module color_game_top
#(
    parameter int tick_base = 1_666_666
)
(
    input  logic                       clock,
    input  logic                       reset,
    input  color_game_pkg::speed_sel_t speed_sel,
    input  logic                       start,
    input  logic                       two_player,
    input  color_game_pkg::colour_t    keys_1,
    input  color_game_pkg::colour_t    keys_2,
    output color_game_pkg::x_coord_t   pixel_x,
    output color_game_pkg::y_coord_t   pixel_y,
    output color_game_pkg::colour_t    pixel_colour,
    output logic                       plot,
    output logic                       game_over,
    output color_game_pkg::seg_t       tens_1,
    output color_game_pkg::seg_t       ones_1,
    output logic [7:0]                 lives_led_1,
    output color_game_pkg::seg_t       tens_2,
    output color_game_pkg::seg_t       ones_2,
    output logic [7:0]                 lives_led_2
);

    import color_game_pkg::*;

    logic    tick;
    logic    judge;
    colour_t judge_colour;
    score_t  score_1;
    score_t  score_2;
    lives_t  lives_1;
    lives_t  lives_2;

    tick_divider #(
        .tick_base(tick_base)
    ) i_tick_divider (
        .clock    (clock),
        .reset    (reset),
        .speed_sel(speed_sel),
        .tick     (tick)
    );

    screen_painter i_screen_painter (
        .clock       (clock),
        .reset       (reset),
        .tick        (tick),
        .start       (start),
        .two_player  (two_player),
        .lives_1     (lives_1),
        .lives_2     (lives_2),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_colour(pixel_colour),
        .plot        (plot),
        .judge       (judge),
        .judge_colour(judge_colour),
        .game_over   (game_over)
    );

    player_tracker i_tracker_1 (
        .clock       (clock),
        .reset       (reset),
        .enable      (1'b1),  // player 1 always plays
        .judge       (judge),
        .judge_colour(judge_colour),
        .keys        (keys_1),
        .score       (score_1),
        .lives       (lives_1)
    );

    player_tracker i_tracker_2 (
        .clock       (clock),
        .reset       (reset),
        .enable      (two_player),
        .judge       (judge),
        .judge_colour(judge_colour),
        .keys        (keys_2),
        .score       (score_2),
        .lives       (lives_2)
    );

    player_panel i_panel_1 (
        .score    (score_1),
        .lives    (lives_1),
        .tens     (tens_1),
        .ones     (ones_1),
        .lives_led(lives_led_1)
    );

    player_panel i_panel_2 (
        .score    (score_2),
        .lives    (lives_2),
        .tens     (tens_2),
        .ones     (ones_2),
        .lives_led(lives_led_2)
    );

endmodule

/* hw/player_panel.sv */
module player_panel
(
    input  color_game_pkg::score_t score,
    input  color_game_pkg::lives_t lives,
    output color_game_pkg::seg_t   tens,
    output color_game_pkg::seg_t   ones,
    output logic [7:0]             lives_led
);

    import color_game_pkg::*;

    logic [3:0] tens_digit;
    logic [3:0] ones_digit;

    // decimal digit to active-low segments, g down to a
    function automatic seg_t seven_seg(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0011000;
            default: return 7'b1111111;  // blank
        endcase
    endfunction

    always_comb
    begin
        tens_digit = 4'(score / 10);  // score stays below 100
        ones_digit = 4'(score % 10);
    end

    assign tens = seven_seg(tens_digit);
    assign ones = seven_seg(ones_digit);

    // bar grows from bit 0, one led per life
    always_comb
    begin
        for (int i = 0; i < 8; i++)
            lives_led[i] = (lives > lives_t'(i));
    end

endmodule

/* hw/player_tracker.sv */
module player_tracker
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enable,
    input  logic                    judge,
    input  color_game_pkg::colour_t judge_colour,
    input  color_game_pkg::colour_t keys,
    output color_game_pkg::score_t  score,
    output color_game_pkg::lives_t  lives
);

    import color_game_pkg::*;

    logic   no_keys;
    logic   hit;
    score_t penalty;
    score_t raised;
    score_t lowered;

    assign no_keys = (keys == '0);
    assign hit     = !no_keys && (keys == judge_colour);

    // an empty press costs less than a wrong one
    assign penalty = no_keys ? score_t'(1) : score_t'(2);

    always_comb
    begin
        if (score > score_t'(max_score - 2))
            raised = max_score;  // saturate
        else
            raised = score + score_t'(2);

        if (score > penalty)
            lowered = score - penalty;
        else
            lowered = '0;  // floor at zero
    end

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            score <= '0;
            lives <= start_lives;
        end
        else if (!enable)
        begin
            score <= '0;  // idle player shows a fresh display
            lives <= start_lives;
        end
        else if (judge)
        begin
            if (hit)
                score <= raised;
            else
            begin
                score <= lowered;
                if (lives != '0)
                    lives <= lives - 1'b1;
            end
        end
    end

endmodule

/* hw/screen_painter.sv */
module screen_painter
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     tick,
    input  logic                     start,
    input  logic                     two_player,
    input  color_game_pkg::lives_t   lives_1,
    input  color_game_pkg::lives_t   lives_2,
    output color_game_pkg::x_coord_t pixel_x,
    output color_game_pkg::y_coord_t pixel_y,
    output color_game_pkg::colour_t  pixel_colour,
    output logic                     plot,
    output logic                     judge,
    output color_game_pkg::colour_t  judge_colour,
    output logic                     game_over
);

    import color_game_pkg::*;

    localparam int checkpoint_last = checkpoint_first + 4 * checkpoint_step;
    localparam int note_idx_width  = $clog2(note_count);

    painter_state_t            state;
    x_coord_t                  cur_x;
    y_coord_t                  cur_y;
    x_coord_t                  next_check;  // column of the next checkpoint in this row
    logic [note_idx_width-1:0] note_idx;    // next entry of note_pattern
    colour_t                   note_now;
    logic                      lost;
    logic                      at_check;
    logic                      draw_bar;
    logic                      draw_note;

    assign note_now = note_pattern[3 * (note_count - 1 - int'(note_idx)) +: 3];

    // player 2 only counts in two-player mode
    assign lost = (lives_1 == '0) || (two_player && (lives_2 == '0));

    assign at_check  = (cur_x == next_check);
    assign draw_bar  = (state == setup_bar);
    assign draw_note = (state == play_row) && tick && !lost;

    assign game_over = (state == color_game_pkg::game_over);

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            state      <= setup_bar;
            cur_x      <= x_coord_t'(checkpoint_first);  // first bar column
            cur_y      <= '0;
            next_check <= x_coord_t'(checkpoint_first);
            note_idx   <= '0;
            plot       <= 1'b0;
            judge      <= 1'b0;
        end
        else
        begin
            plot  <= draw_bar || draw_note;
            judge <= draw_note && at_check;

            case (state)
                setup_bar:
                begin
                    if (cur_y == y_coord_t'(screen_height - 1))
                    begin
                        cur_y <= '0;
                        state <= next_bar;
                    end
                    else
                        cur_y <= cur_y + 1'b1;
                end

                next_bar:
                begin
                    if (cur_x == x_coord_t'(checkpoint_last))  // all five bars done
                    begin
                        cur_x <= '0;
                        cur_y <= y_coord_t'(row_first);
                        state <= wait_start;
                    end
                    else
                    begin
                        cur_x <= cur_x + x_coord_t'(checkpoint_step);
                        state <= setup_bar;
                    end
                end

                wait_start:
                begin
                    if (start)
                        state <= play_row;
                end

                play_row:
                begin
                    if (lost)
                        state <= color_game_pkg::game_over;
                    else if (tick)
                    begin
                        if (at_check)
                        begin
                            next_check <= next_check + x_coord_t'(checkpoint_step);
                            if (note_idx == note_idx_width'(note_count - 1))
                                note_idx <= '0;  // pattern wraps
                            else
                                note_idx <= note_idx + 1'b1;
                        end

                        if (cur_x == x_coord_t'(screen_width - 1))
                        begin
                            cur_x <= '0;
                            if (cur_y == y_coord_t'(row_last))
                                state <= color_game_pkg::game_over;  // rows ran out
                            else
                                state <= next_row;
                        end
                        else
                            cur_x <= cur_x + 1'b1;
                    end
                end

                next_row:
                begin
                    next_check <= x_coord_t'(checkpoint_first);
                    if (lost)
                        state <= color_game_pkg::game_over;
                    else
                    begin
                        cur_y <= cur_y + y_coord_t'(row_step);
                        state <= play_row;
                    end
                end

                default:
                    state <= state;  // game over holds until reset
            endcase
        end
    end

    // pixel and note payload, qualified by plot and judge
    always_ff @(posedge clock)
    begin
        if (draw_bar || draw_note)
        begin
            pixel_x <= cur_x;
            pixel_y <= cur_y;
        end

        if (draw_bar)
            pixel_colour <= bar_colour;
        else if (draw_note && at_check)
            pixel_colour <= note_now;  // row keeps this colour up to the next checkpoint

        if (draw_note && at_check)
            judge_colour <= note_now;
    end

endmodule

/* hw/tick_divider.sv */
module tick_divider
#(
    parameter int tick_base = 1_666_666
)
(
    input  logic                       clock,
    input  logic                       reset,
    input  color_game_pkg::speed_sel_t speed_sel,
    output logic                       tick
);

    localparam int count_width = (tick_base < 2) ? 1 : $clog2(tick_base + 1);

    logic [count_width-1:0] count;
    logic [count_width-1:0] period;

    assign period = count_width'(tick_base >> speed_sel);  // each step halves the period

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (count >= period)  // also catches a shorter period picked mid count
        begin
            count <= '0;
            tick  <= 1'b1;
        end
        else
        begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

/* sim/tb_color_game.sv */
module tb_color_game;

    timeunit 1ns;
    timeprecision 100ps;

    import color_game_pkg::*;

    typedef enum logic [1:0] {key_none, key_match, key_wrong} key_mode_t;

    typedef struct packed {
        key_mode_t mode_1;
        key_mode_t mode_2;
    } entry_t;

    // player 1 loses its eighth life on the last entry, player 2 only four
    localparam int entry_count = 13;
    localparam entry_t lives_table [entry_count] = '{
        '{key_match, key_match}, '{key_none, key_match}, '{key_wrong, key_none},
        '{key_match, key_wrong}, '{key_wrong, key_match}, '{key_none, key_match},
        '{key_match, key_none}, '{key_wrong, key_match}, '{key_match, key_match},
        '{key_none, key_wrong}, '{key_wrong, key_match}, '{key_match, key_match},
        '{key_wrong, key_match}
    };

    // active-low digits, g down to a
    localparam seg_t seg_table [10] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0011000
    };

    logic        clock;
    logic        reset;
    speed_sel_t  speed_sel;
    logic        start;
    logic        two_player;
    colour_t     keys_1;
    colour_t     keys_2;
    x_coord_t    pixel_x;
    y_coord_t    pixel_y;
    colour_t     pixel_colour;
    logic        plot;
    logic        game_over;
    seg_t        tens_1;
    seg_t        ones_1;
    logic [7:0]  lives_led_1;
    seg_t        tens_2;
    seg_t        ones_2;
    logic [7:0]  lives_led_2;

    int          cycle_count = 0;
    int          last_plot;     // cycle of the previous play pixel, -1 before the first
    int          period;        // expected clocks between play pixels
    int          judged;        // notes judged in this run
    int          score_1;
    int          lives_1;
    int          score_2;
    int          lives_2;
    logic [31:0] lfsr_state = 32'hab9f_ad06;

    color_game_top #(
        .tick_base(6)
    ) i_dut (
        .clock       (clock),
        .reset       (reset),
        .speed_sel   (speed_sel),
        .start       (start),
        .two_player  (two_player),
        .keys_1      (keys_1),
        .keys_2      (keys_2),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_colour(pixel_colour),
        .plot        (plot),
        .game_over   (game_over),
        .tens_1      (tens_1),
        .ones_1      (ones_1),
        .lives_led_1 (lives_led_1),
        .tens_2      (tens_2),
        .ones_2      (ones_2),
        .lives_led_2 (lives_led_2)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock)
        cycle_count <= cycle_count + 1;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual)
            stop_run($sformatf("ERROR %s expected %0d actual %0d", name, expected, actual));
    endtask

    function automatic logic random_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb)
            lfsr_state = lfsr_state ^ 32'h8020_0003;  // galois taps 32, 22, 2, 1
        return lsb;
    endfunction

    function automatic colour_t note_at(input int idx);
        return note_pattern[3 * (note_count - idx) - 1 -: 3];  // entry 0 on top
    endfunction

    function automatic colour_t keys_for(input key_mode_t mode, input colour_t note);
        colour_t value;
        if (mode == key_none)
            return '0;
        if (mode == key_match)
            return note;
        do
        begin
            for (int i = 0; i < 3; i++)
                value[i] = random_bit();
        end
        while (value == '0 || value == note);  // pressed but not the note
        return value;
    endfunction

    task automatic apply_rule(input colour_t keys, input colour_t note,
                              inout int score, inout int lives);
        if (keys == note)
            score = (score + 2 > 99) ? 99 : score + 2;
        else
        begin
            score = score - ((keys == '0) ? 1 : 2);
            score = (score < 0) ? 0 : score;
            lives = (lives > 0) ? lives - 1 : 0;
        end
    endtask

    task automatic check_panel(input string who, input int score, input int lives,
                               input seg_t tens, input seg_t ones, input logic [7:0] leds);
        check_value({who, " tens"}, seg_table[score / 10], tens);
        check_value({who, " ones"}, seg_table[score % 10], ones);
        check_value({who, " lives led"}, 8'((9'd1 << lives) - 9'd1), leds);
    endtask

    task automatic restart(input speed_sel_t sel, input logic two);
        @(posedge clock);
        reset      <= 1'b0;
        start      <= 1'b0;
        speed_sel  <= sel;
        two_player <= two;
        repeat (4) @(posedge clock);
        reset      <= 1'b1;
        period    = (6 >> sel) + 1;
        last_plot = -1;
        judged    = 0;
        score_1   = 0;
        lives_1   = 8;
        score_2   = 0;
        lives_2   = 8;
    endtask

    // five bars of 120 rows, then nothing while start stays low
    task automatic check_setup();
        int plots;
        plots = 0;
        repeat (700)
        begin
            @(negedge clock);
            if (plot)
            begin
                check_value("bar column", checkpoint_first + checkpoint_step * (plots / 120),
                            pixel_x);
                check_value("bar row", plots % 120, pixel_y);
                check_value("bar colour", bar_colour, pixel_colour);
                plots++;
            end
        end
        check_value("bar pixel count", 600, plots);
    endtask

    task automatic next_plot();
        int waited;
        waited = 0;
        do
        begin
            @(negedge clock);
            waited++;
            if (waited > 4 * period + 8)
                stop_run("timed out waiting for a pixel write");
        end
        while (!plot);
        if (last_plot >= 0)
            check_value("plot spacing", period, cycle_count - last_plot);
        last_plot = cycle_count;
    endtask

    task automatic play_entry(input key_mode_t mode_1, input key_mode_t mode_2);
        colour_t note;
        colour_t k1;
        colour_t k2;
        int      plots;
        note = note_at(judged % note_count);
        k1   = keys_for(mode_1, note);
        k2   = keys_for(mode_2, note);
        @(posedge clock);
        keys_1 <= k1;
        keys_2 <= k2;
        plots = 0;
        do
        begin
            next_plot();
            plots++;
            if (plots > 200)
                stop_run("no checkpoint pixel was written");
        end
        while (!(pixel_x >= checkpoint_first && pixel_x <= checkpoint_first + 4 * checkpoint_step
                 && (pixel_x - checkpoint_first) % checkpoint_step == 0));
        check_value("note colour", note, pixel_colour);
        check_value("note row", row_first + row_step * (judged / 5), pixel_y);
        check_value("game over during play", 0, game_over);
        apply_rule(k1, note, score_1, lives_1);
        if (two_player)
            apply_rule(k2, note, score_2, lives_2);
        @(negedge clock);  // trackers update one clock after the judge
        check_panel("player 1", score_1, lives_1, tens_1, ones_1, lives_led_1);
        check_panel("player 2", score_2, lives_2, tens_2, ones_2, lives_led_2);
        judged++;
    endtask

    task automatic wait_game_over();
        int waited;
        waited = 0;
        while (!game_over)
        begin
            @(negedge clock);
            waited++;
            if (waited > 10)
                stop_run("game over did not rise");
        end
    endtask

    task automatic check_frozen();
        repeat (40)
        begin
            @(negedge clock);
            check_value("plot after game over", 0, plot);
            check_value("game over level", 1, game_over);
            check_panel("frozen player 1", score_1, lives_1, tens_1, ones_1, lives_led_1);
            check_panel("frozen player 2", score_2, lives_2, tens_2, ones_2, lives_led_2);
        end
    endtask

    initial
    begin
        int tail_plots;

        reset      <= 1'b0;
        start      <= 1'b0;
        speed_sel  <= '0;
        two_player <= 1'b0;
        keys_1     <= '0;
        keys_2     <= '0;

        // run 1, two players, player 1 runs out of lives
        restart(2'd0, 1'b1);
        check_setup();
        @(posedge clock);
        start <= 1'b1;
        for (int i = 0; i < entry_count; i++)
            play_entry(lives_table[i].mode_1, lives_table[i].mode_2);
        wait_game_over();
        check_frozen();

        // run 2, one player at the fastest rate, rows run out
        restart(2'd2, 1'b0);
        check_setup();
        @(posedge clock);
        start <= 1'b1;
        repeat (16 * 5)
            play_entry(key_match, key_wrong);
        check_value("saturated tens", seg_table[9], tens_1);
        tail_plots = 0;
        do
        begin
            check_value("game over before last pixel", 0, game_over);
            next_plot();
            tail_plots++;
            if (tail_plots > screen_width)
                stop_run("the last pixel of the last row was not written");
        end
        while (!(pixel_x == screen_width - 1 && pixel_y == row_last));
        wait_game_over();
        check_frozen();

        $display("All checks passed");
        $finish;
    end

endmodule

/* verilog.f */
hw/color_game_pkg.sv
hw/tick_divider.sv
hw/screen_painter.sv
hw/player_tracker.sv
hw/player_panel.sv
hw/color_game_top.sv
sim/tb_color_game.sv
